// File: hw/div_array_top.sv
/*
 * pipelined non-restoring divider top level
 * operand prep, chain of array stage groups, result fixup
 */
`timescale 1ns/1ps
`default_nettype none

module div_array_top #(
	// must divide DIV_WIDTH
	parameter int ROWS_PER_STAGE = div_cfg_pkg::DIV_ROWS_DEFAULT
) (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     in_valid,
	input  div_types_pkg::div_req_t  req,
	output logic                     out_valid,
	output div_types_pkg::div_resp_t resp
);

	localparam int STAGES = div_cfg_pkg::DIV_WIDTH / ROWS_PER_STAGE;

	// link k feeds stage group k, link STAGES feeds the fixup
	logic                     stage_valid [STAGES+1];
	div_types_pkg::div_work_t stage_work  [STAGES+1];

	div_operand_prep u_prep (
		.clk        (clk),
		.arst_n     (arst_n),
		.in_valid   (in_valid),
		.req        (req),
		.work_valid (stage_valid[0]),
		.work       (stage_work[0])
	);

	// DIV_WIDTH rows in total, ROWS_PER_STAGE per register stage
	for (genvar s = 0; s < STAGES; s++) begin : g_stage
		div_stage_group #(
			.ROWS_PER_STAGE (ROWS_PER_STAGE)
		) u_group (
			.clk       (clk),
			.arst_n    (arst_n),
			.in_valid  (stage_valid[s]),
			.work_in   (stage_work[s]),
			.out_valid (stage_valid[s+1]),
			.work_out  (stage_work[s+1])
		);
	end

	div_result_fixup u_fixup (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (stage_valid[STAGES]),
		.work      (stage_work[STAGES]),
		.out_valid (out_valid),
		.resp      (resp)
	);

endmodule

`default_nettype wire

// File: hw/div_cfg_pkg.sv
/*
 * divider widths, default rows per pipeline stage and latency helper
 */
`default_nettype none

package div_cfg_pkg;

	// operand width, fixed because the packed structs depend on it
	localparam int DIV_WIDTH = 32;

	// sign-extended operand, one bit wider than an operand
	localparam int DIV_MAG_WIDTH = DIV_WIDTH + 1;

	// partial remainder, wide enough for 2*divisor plus sign
	localparam int DIV_REM_WIDTH = DIV_WIDTH + 2;

	// array rows done in one pipeline stage
	localparam int DIV_ROWS_DEFAULT = 4;

	// prep stage + array stages + fixup stage
	function automatic int DIV_LATENCY(input int rows_per_stage);
		return 2 + DIV_WIDTH / rows_per_stage;
	endfunction

endpackage

`default_nettype wire

// File: hw/div_operand_prep.sv
/*
 * operand conditioning stage: magnitudes, sign flags, initial array state
 */
`timescale 1ns/1ps
`default_nettype none

module div_operand_prep (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     in_valid,
	input  div_types_pkg::div_req_t  req,
	output logic                     work_valid,
	output div_types_pkg::div_work_t work
);

	localparam int W     = div_cfg_pkg::DIV_WIDTH;
	localparam int MAG_W = div_cfg_pkg::DIV_MAG_WIDTH;

	logic             dvd_neg;
	logic             dvs_neg;
	logic [MAG_W-1:0] dvd_ext;
	logic [MAG_W-1:0] dvs_ext;
	logic [MAG_W-1:0] dvd_mag;
	logic [MAG_W-1:0] dvs_mag;

	// operand is negative only in signed mode
	assign dvd_neg = req.is_signed & req.dividend[W-1];
	assign dvs_neg = req.is_signed & req.divisor[W-1];

	// sign extension in signed mode, zero extension otherwise
	assign dvd_ext = {dvd_neg, req.dividend};
	assign dvs_ext = {dvs_neg, req.divisor};

	// two's complement negate to get magnitudes
	assign dvd_mag = dvd_neg ? (~dvd_ext + 1'b1) : dvd_ext;
	assign dvs_mag = dvs_neg ? (~dvs_ext + 1'b1) : dvs_ext;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			work_valid <= 1'b0;
		end else begin
			work_valid <= in_valid;
		end
	end

	// payload only moves with a valid request
	always_ff @(posedge clk) begin
		if (in_valid) begin
			work.part_rem      <= '0;
			work.quot          <= '0;
			// magnitude of the most negative value still fits in W bits
			work.dvd_rest      <= dvd_mag[W-1:0];
			work.divisor_mag   <= dvs_mag;
			work.sign.neg_quot <= dvd_neg ^ dvs_neg;
			work.sign.neg_rem  <= dvd_neg;
		end
	end

	// an X on the request would travel unnoticed through the whole pipe
	a_req_known: assert property (
		@(posedge clk) disable iff (!arst_n)
		in_valid |-> !$isunknown(req)
	) else $error("div_operand_prep: request has unknown bits");

endmodule

`default_nettype wire

// File: hw/div_result_fixup.sv
/*
 * final stage: remainder restore, sign correction, response register
 */
`timescale 1ns/1ps
`default_nettype none

module div_result_fixup (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     in_valid,
	input  div_types_pkg::div_work_t work,
	output logic                     out_valid,
	output div_types_pkg::div_resp_t resp
);

	localparam int W     = div_cfg_pkg::DIV_WIDTH;
	localparam int REM_W = div_cfg_pkg::DIV_REM_WIDTH;

	logic [REM_W-1:0] divisor_ext;
	logic [REM_W-1:0] rem_restored;
	logic [W-1:0]     rem_mag;
	logic [W-1:0]     quot_fixed;
	logic [W-1:0]     rem_fixed;

	assign divisor_ext = {1'b0, work.divisor_mag};

	// last row may leave a negative remainder, add the divisor back once
	assign rem_restored = work.part_rem[REM_W-1] ? (work.part_rem + divisor_ext)
	                                             : work.part_rem;

	// restored value is below the divisor, so W bits are enough
	assign rem_mag = rem_restored[W-1:0];

	// quotient truncates toward zero, remainder follows the dividend sign
	assign quot_fixed = work.sign.neg_quot ? (~work.quot + 1'b1) : work.quot;
	assign rem_fixed  = work.sign.neg_rem ? (~rem_mag + 1'b1) : rem_mag;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			resp.remainder <= rem_fixed;
			resp.quotient  <= quot_fixed;
		end
	end

	// holds only if all array rows upstream did their add/subtract right
	a_rem_below_divisor: assert property (
		@(posedge clk) disable iff (!arst_n)
		in_valid |-> (rem_restored < divisor_ext)
	) else $error("div_result_fixup: remainder not below divisor");

endmodule

`default_nettype wire

// File: hw/div_stage_group.sv
/*
 * one pipeline stage of non-restoring divider rows plus its register
 */
`timescale 1ns/1ps
`default_nettype none

module div_stage_group #(
	parameter int ROWS_PER_STAGE = div_cfg_pkg::DIV_ROWS_DEFAULT
) (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     in_valid,
	input  div_types_pkg::div_work_t work_in,
	output logic                     out_valid,
	output div_types_pkg::div_work_t work_out
);

	localparam int W     = div_cfg_pkg::DIV_WIDTH;
	localparam int REM_W = div_cfg_pkg::DIV_REM_WIDTH;

	// row_work[0] is the stage input and row_work[ROWS_PER_STAGE] feeds the register
	div_types_pkg::div_work_t row_work [ROWS_PER_STAGE+1];

	assign row_work[0] = work_in;

	for (genvar i = 0; i < ROWS_PER_STAGE; i++) begin : g_row
		logic [REM_W-1:0] divisor_ext;
		logic [REM_W-1:0] shifted_rem;
		logic [REM_W-1:0] next_rem;

		assign divisor_ext = {1'b0, row_work[i].divisor_mag};

		// bring down the next dividend bit
		assign shifted_rem = {row_work[i].part_rem[REM_W-2:0], row_work[i].dvd_rest[W-1]};

		// subtract while non-negative, add back otherwise
		assign next_rem = row_work[i].part_rem[REM_W-1] ? (shifted_rem + divisor_ext)
		                                                : (shifted_rem - divisor_ext);

		// quotient bit is set when the new remainder is non-negative
		assign row_work[i+1] = '{
			part_rem:    next_rem,
			quot:        {row_work[i].quot[W-2:0], ~next_rem[REM_W-1]},
			dvd_rest:    {row_work[i].dvd_rest[W-2:0], 1'b0},
			divisor_mag: row_work[i].divisor_mag,
			sign:        row_work[i].sign
		};
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			work_out <= row_work[ROWS_PER_STAGE];
		end
	end

	// partial remainder stays within one divisor of zero
	a_rem_in_range: assert property (
		@(posedge clk) disable iff (!arst_n)
		out_valid |-> ($signed(work_out.part_rem) >= -$signed({1'b0, work_out.divisor_mag}) &&
		               $signed(work_out.part_rem) <  $signed({1'b0, work_out.divisor_mag}))
	) else $error("div_stage_group: partial remainder out of range");

endmodule

`default_nettype wire

// File: hw/div_types_pkg.sv
/*
 * request, sign flag, array work state and response structs
 */
`default_nettype none

package div_types_pkg;

	// one divide request as presented at the top level
	typedef struct packed {
		logic [div_cfg_pkg::DIV_WIDTH-1:0] dividend;
		logic [div_cfg_pkg::DIV_WIDTH-1:0] divisor;
		logic                              is_signed;
	} div_req_t;

	// result corrections, carried down the pipe with the data
	typedef struct packed {
		// signed op with differing operand signs
		logic neg_quot;
		// signed op with negative dividend
		logic neg_rem;
	} div_sign_t;

	// state passed from one array row to the next
	typedef struct packed {
		// msb is the sign, picks add or subtract in the next row
		logic [div_cfg_pkg::DIV_REM_WIDTH-1:0] part_rem;
		// quotient bits so far, new bits enter at bit 0
		logic [div_cfg_pkg::DIV_WIDTH-1:0]     quot;
		// dividend bits still to be consumed, msb first
		logic [div_cfg_pkg::DIV_WIDTH-1:0]     dvd_rest;
		logic [div_cfg_pkg::DIV_MAG_WIDTH-1:0] divisor_mag;
		div_sign_t                             sign;
	} div_work_t;

	// remainder in the upper half, quotient in the lower half
	typedef struct packed {
		logic [div_cfg_pkg::DIV_WIDTH-1:0] remainder;
		logic [div_cfg_pkg::DIV_WIDTH-1:0] quotient;
	} div_resp_t;

endpackage

`default_nettype wire

// File: sim/div_tb.sv
/*
 * testbench for the pipelined divider: clock, reset, stimulus,
 * expected-result queue, checking assertions and final report
 */
`timescale 1ns/1ps
`default_nettype none

module div_tb;

	localparam int LAT = div_cfg_pkg::DIV_LATENCY(div_cfg_pkg::DIV_ROWS_DEFAULT);

	logic                     clk;
	logic                     arst_n;
	logic                     in_valid;
	div_types_pkg::div_req_t  req;
	logic                     out_valid;
	div_types_pkg::div_resp_t resp;

	// outstanding expectations, oldest first
	div_types_pkg::div_resp_t exp_q[$];
	string                    name_q[$];
	int                       issue_q[$];

	// last popped result, stable from one falling edge to the next
	logic                     chk_valid = 1'b0;
	logic                     chk_have = 1'b0;
	div_types_pkg::div_resp_t head_exp;
	div_types_pkg::div_resp_t act_resp;
	string                    head_name;
	int                       head_age;

	int    cycle = 0;
	int    errors = 0;
	int    n_ops = 0;
	int    n_tests = 0;
	int    n_failed = 0;
	int    test_ops;
	int    test_err;
	string cur_test = "none";
	logic  aborted = 1'b0;

	div_array_top #(
		.ROWS_PER_STAGE (div_cfg_pkg::DIV_ROWS_DEFAULT)
	) dut_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.req       (req),
		.out_valid (out_valid),
		.resp      (resp)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		arst_n = 1'b0;
		repeat (8) @(posedge clk);
		arst_n <= 1'b1;
	end

	always @(posedge clk) cycle <= cycle + 1;

	// reference rule: truncating division, remainder keeps the dividend sign
	function automatic div_types_pkg::div_resp_t expected_resp(input div_types_pkg::div_req_t r);
		logic signed [31:0] dvd_s;
		logic signed [31:0] dvs_s;
		logic [31:0]        q;
		logic [31:0]        m;
		if (r.is_signed) begin
			dvd_s = r.dividend;
			dvs_s = r.divisor;
			q = dvd_s / dvs_s;
			m = dvd_s % dvs_s;
		end else begin
			q = r.dividend / r.divisor;
			m = r.dividend % r.divisor;
		end
		return '{remainder: m, quotient: q};
	endfunction

	function automatic div_types_pkg::div_req_t random_req();
		return '{dividend: $urandom, divisor: $urandom, is_signed: $urandom_range(1, 0)};
	endfunction

	// inputs and outputs are both taken at the falling edge before the
	// rising edge that samples them, so the age is counted in edges
	always @(negedge clk) begin
		chk_valid = 1'b0;
		chk_have = 1'b0;
		if (arst_n && out_valid) begin
			chk_valid = 1'b1;
			act_resp = resp;
			if (exp_q.size() > 0) begin
				chk_have = 1'b1;
				head_exp = exp_q.pop_front();
				head_name = name_q.pop_front();
				head_age = cycle - issue_q.pop_front();
			end
		end
		if (arst_n && in_valid) begin
			exp_q.push_back(expected_resp(req));
			name_q.push_back(cur_test);
			issue_q.push_back(cycle);
		end
	end

	a_quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !out_valid)
		else begin
			errors++;
			$display("out_valid went high while reset was asserted");
		end

	a_result_expected: assert property (@(posedge clk) disable iff (!arst_n)
		chk_valid |-> chk_have)
		else begin
			errors++;
			$display("out_valid pulsed with no request outstanding in %s", cur_test);
		end

	a_result_value: assert property (@(posedge clk) disable iff (!arst_n)
		(chk_valid && chk_have) |-> (act_resp == head_exp))
		else begin
			errors++;
			$display("FAILED %s expected %h actual %h", head_name, head_exp, act_resp);
		end

	a_result_latency: assert property (@(posedge clk) disable iff (!arst_n)
		(chk_valid && chk_have) |-> (head_age == LAT))
		else begin
			errors++;
			$display("result for %s arrived %0d cycles after its request, not %0d",
			         head_name, head_age, LAT);
		end

	task automatic issue(input logic [31:0] a, input logic [31:0] b, input logic s);
		@(posedge clk);
		in_valid <= 1'b1;
		req <= '{dividend: a, divisor: b, is_signed: s};
		n_ops++;
		test_ops++;
	endtask

	// random payload with in_valid low must be ignored
	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			in_valid <= 1'b0;
			req <= random_req();
		end
	endtask

	task automatic issue_random(input logic s);
		logic [31:0] a;
		logic [31:0] b;
		a = $urandom;
		// spread divisor magnitudes over the whole range
		b = $urandom >> ($urandom % 32);
		if (b == 0)
			b = 1;
		if (s && a == 32'h8000_0000 && b == 32'hffff_ffff)
			b = 32'h2;
		issue(a, b, s);
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		while (arst_n !== 1'b1 && n < 20) begin
			@(posedge clk);
			n++;
		end
		if (arst_n !== 1'b1) begin
			$display("timeout: reset was never released");
			aborted = 1'b1;
		end
	endtask

	task automatic test_begin(input string name);
		cur_test = name;
		test_ops = 0;
		test_err = errors;
	endtask

	task automatic test_end();
		int n;
		n = 0;
		idle(1);
		while (exp_q.size() > 0 && n < LAT + 20) begin
			@(posedge clk);
			n++;
		end
		if (exp_q.size() > 0) begin
			$display("timeout: %0d results of %s never came out", exp_q.size(), cur_test);
			aborted = 1'b1;
		end
		// let the last popped result reach its assertions
		idle(2);
		n_tests++;
		if (errors != test_err || aborted)
			n_failed++;
		$display("test %-12s ops %3d errors %0d", cur_test, test_ops, errors - test_err);
	endtask

	task automatic run_sign_rules();
		test_begin("sign_rules");
		for (int s = 1; s >= 0; s--) begin
			issue(32'd7, 32'd2, s);
			issue(-32'sd7, 32'd2, s);
			issue(32'd7, -32'sd2, s);
			issue(-32'sd7, -32'sd2, s);
			idle(2);
		end
		test_end();
	endtask

	task automatic run_corners();
		test_begin("corners");
		issue(32'd0, 32'd5, 1'b0);
		issue(32'd0, -32'sd3, 1'b1);
		issue(32'd12345, 32'd1, 1'b0);
		issue(-32'sd12345, 32'd1, 1'b1);
		issue(32'd3, 32'd10, 1'b0);
		issue(-32'sd3, 32'd10, 1'b1);
		issue(32'd3, -32'sd10, 1'b1);
		issue(32'hffff_ffff, 32'd7, 1'b0);
		issue(32'hffff_ffff, 32'd1, 1'b0);
		issue(32'h8000_0000, 32'd2, 1'b1);
		test_end();
	endtask

	task automatic run_random_gaps();
		test_begin("random_gaps");
		for (int i = 0; i < 60; i++) begin
			issue_random(i % 2);
			idle($urandom_range(4, 1));
		end
		test_end();
	endtask

	task automatic run_back_to_back();
		test_begin("back_to_back");
		for (int i = 0; i < 40; i++)
			issue_random($urandom_range(1, 0));
		test_end();
	endtask

	initial begin
		void'($urandom(32'h8c79d80a));
		in_valid = 1'b0;
		req = random_req();
		wait_reset_release();
		if (!aborted) begin
			// idle pipe after reset, nothing may come out
			test_begin("reset");
			idle(LAT + 4);
			test_end();
		end
		if (!aborted)
			run_sign_rules();
		if (!aborted)
			run_corners();
		if (!aborted)
			run_random_gaps();
		if (!aborted)
			run_back_to_back();
		$display("tests %0d, failed %0d, operations %0d, errors %0d",
		         n_tests, n_failed, n_ops, errors);
		if (errors == 0 && n_failed == 0 && !aborted) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
hw/div_cfg_pkg.sv
hw/div_types_pkg.sv
hw/div_operand_prep.sv
hw/div_stage_group.sv
hw/div_result_fixup.sv
hw/div_array_top.sv
sim/div_tb.sv
